// File: logic/fds_defines.svh
// Register addresses, drive timing defaults, disk image layout and field widths
`ifndef FDS_DEFINES_SVH
`define FDS_DEFINES_SVH

// CPU register map
`define FDS_ADDR_TLO     16'h4020
`define FDS_ADDR_THI     16'h4021
`define FDS_ADDR_TCTL    16'h4022
`define FDS_ADDR_IOEN    16'h4023
`define FDS_ADDR_WDATA   16'h4024
`define FDS_ADDR_CTRL    16'h4025
`define FDS_ADDR_STATUS  16'h4030
`define FDS_ADDR_RDATA   16'h4031
`define FDS_ADDR_DRIVE   16'h4032
`define FDS_ADDR_EXT     16'h4033

// Drive timing in ce cycles, much shorter than a real drive
`define FDS_PRE_GAP_DEFAULT  16'd65535
`define FDS_BYTE_DEFAULT     16'd99
`define FDS_EJECT_DEFAULT    23'd1786800

// Image layout
`define FDS_SIDE_BYTES    65500
`define FDS_IMAGE_HEADER  16
`define FDS_DISK_END_POS  16'd65499
`define FDS_PRG_AW        22
`define FDS_START_MARK    8'h80

// Last byte index per block type
`define FDS_BLK_INFO_LEN    16'h0037
`define FDS_BLK_COUNT_LEN   16'h0001
`define FDS_BLK_HEADER_LEN  16'h000F

`endif

// File: logic/fds_pkg.sv
// Package with the bus, control, status and PRG mapping struct types
`default_nettype none

`include "fds_defines.svh"

package fds_pkg;

	// One CPU access as seen by the cartridge
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        read;
		logic        write;
	} cpu_bus_t;

	// Decoded $4025 contents
	typedef struct packed {
		logic motor_on;
		logic head_home;       // Drive head back at the start of the disk
		logic write_mode;
		logic vertical_mirror;
		logic transfer_on;
		logic disk_irq_en;
	} disk_ctrl_t;

	typedef struct packed {
		logic byte_ready;
		logic disk_end;
	} disk_status_t;

	typedef struct packed {
		logic [`FDS_PRG_AW-1:0] aout;
		logic                   allow;   // Memory may take part in this access
	} prg_map_t;

endpackage

`default_nettype wire

// File: logic/fds_interval_timer.sv
// Interval timer with reload latch, repeat mode and timer IRQ
`timescale 1ns/10ps
`default_nettype none

`include "fds_defines.svh"

module fds_interval_timer import fds_pkg::*; (
	input  logic     clk,
	input  logic     diskreset,
	input  logic     ce,
	input  cpu_bus_t cpu,
	input  logic     status_read,
	output logic     timer_irq
);

	logic [15:0] latch;
	logic [15:0] count;
	logic        repeat_mode;
	logic        timer_en;
	logic        reg_en;      // $4023 bit 0, gates the whole disk register set
	logic        read_pend;

	always_ff @(posedge clk) begin
		if (diskreset) begin
			repeat_mode <= 1'b0;
			timer_en    <= 1'b0;
			reg_en      <= 1'b0;
			timer_irq   <= 1'b0;
			read_pend   <= 1'b0;
		end else if (ce) begin
			if (timer_en) begin
				if (count == 16'd0) begin
					timer_irq <= 1'b1;
					count     <= latch;
					if (!repeat_mode)
						timer_en <= 1'b0;  // One-shot stops here
				end else begin
					count <= count - 16'd1;
				end
			end

			if (cpu.write) begin
				case (cpu.addr)
					`FDS_ADDR_TLO: latch[7:0]  <= cpu.wdata;
					`FDS_ADDR_THI: latch[15:8] <= cpu.wdata;
					`FDS_ADDR_TCTL: begin
						repeat_mode <= cpu.wdata[0];
						timer_en    <= cpu.wdata[1] & reg_en;
						if (cpu.wdata[1] && reg_en)
							count <= latch;
						else
							timer_irq <= 1'b0;
					end
					`FDS_ADDR_IOEN: begin
						reg_en <= cpu.wdata[0];
						if (!cpu.wdata[0]) begin
							timer_en  <= 1'b0;
							timer_irq <= 1'b0;
						end
					end
					default: ;
				endcase
			end

			// Status read acknowledges one ce late
			read_pend <= status_read;
			if (read_pend)
				timer_irq <= 1'b0;
		end
	end

	a_irq_needs_reg_en: assert property (@(posedge clk) disable iff (diskreset)
		$rose(timer_irq) |-> reg_en);

endmodule

`default_nettype wire

// File: logic/fds_byte_transfer.sv
// Drive byte timing, byte-ready flag, block parsing, block end and head position
`timescale 1ns/10ps
`default_nettype none

`include "fds_defines.svh"

module fds_byte_transfer import fds_pkg::*; #(
	parameter logic [15:0] PRE_GAP_CYCLES = `FDS_PRE_GAP_DEFAULT,
	parameter logic [15:0] BYTE_CYCLES    = `FDS_BYTE_DEFAULT
) (
	input  logic         clk,
	input  logic         diskreset,
	input  logic         ce,
	input  disk_ctrl_t   ctrl,
	input  cpu_bus_t     cpu,
	input  logic         data_write,
	input  logic         data_read,
	input  logic         status_read,
	input  logic         drive_busy,
	input  logic [7:0]   prg_dbus,
	output disk_status_t status,
	output logic         disk_irq,
	output logic [15:0]  disk_pos,
	output logic         disk_access
);

	logic        byte_ready;
	logic        new_byte;       // A slot byte is waiting to be consumed
	logic        after_pre_gap;
	logic        read_pend;
	logic        xfer_d;
	logic        got_start;
	logic        got_start_d;
	logic        read_d;
	logic        write_d;
	logic        block_end;
	logic        blk_last;
	logic [2:0]  block_type;
	logic [15:0] transfer_cnt;
	logic [15:0] byte_cnt;
	logic [15:0] file_size;
	logic [7:0]  disk_data;
	logic        read_disk;
	logic        write_disk;
	logic        disk_end;

	assign disk_end   = (disk_pos == `FDS_DISK_END_POS);
	assign read_disk  = data_read;
	assign write_disk = data_write & ctrl.write_mode & ctrl.transfer_on & got_start_d &
		ctrl.motor_on & ~ctrl.head_home & ~block_end;
	assign disk_access = read_disk | write_disk;
	assign disk_data   = write_disk ? cpu.wdata : prg_dbus;
	assign disk_irq    = byte_ready & ctrl.disk_irq_en;
	assign status      = '{byte_ready: byte_ready, disk_end: disk_end};

	// The image carries no CRC bytes, so block ends come from the block headers
	always_comb begin
		case (block_type)
			3'd1:    blk_last = (byte_cnt == `FDS_BLK_INFO_LEN);
			3'd2:    blk_last = (byte_cnt == `FDS_BLK_COUNT_LEN);
			3'd3:    blk_last = (byte_cnt == `FDS_BLK_HEADER_LEN);
			3'd4:    blk_last = (byte_cnt == file_size);
			default: blk_last = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (diskreset) begin
			byte_ready    <= 1'b0;
			new_byte      <= 1'b0;
			after_pre_gap <= 1'b0;
			read_pend     <= 1'b0;
			xfer_d        <= 1'b0;
			got_start     <= 1'b0;
			got_start_d   <= 1'b0;
			read_d        <= 1'b0;
			write_d       <= 1'b0;
			block_end     <= 1'b0;
			block_type    <= 3'd0;
			transfer_cnt  <= 16'd0;
			byte_cnt      <= 16'd0;
			disk_pos      <= 16'd0;
		end else if (ce) begin
			xfer_d      <= ctrl.transfer_on;
			got_start_d <= got_start;
			read_d      <= read_disk;
			write_d     <= write_disk;
			read_pend   <= status_read;

			if (data_write) begin
				byte_ready <= 1'b0;
				if (ctrl.write_mode && ctrl.transfer_on && cpu.wdata == `FDS_START_MARK)
					got_start <= 1'b1;
			end

			if (read_pend || read_d)
				byte_ready <= 1'b0;

			// Block type and file size from the block contents
			if ((read_disk && !ctrl.write_mode) || write_disk) begin
				if (byte_cnt == 16'd0)
					block_type <= disk_data[2:0];
				if (block_type == 3'd3) begin
					if (byte_cnt == 16'h000D) file_size[7:0]  <= disk_data;
					if (byte_cnt == 16'h000E) file_size[15:8] <= disk_data;
				end
			end

			// Head moves on the ce after the byte was taken
			if (((read_d && !ctrl.write_mode) || write_d) && new_byte) begin
				new_byte <= 1'b0;
				byte_cnt <= byte_cnt + 16'd1;
				if (!disk_end && !block_end)
					disk_pos <= disk_pos + 16'd1;
				if (blk_last)
					block_end <= 1'b1;
			end

			if (!ctrl.motor_on) begin
				transfer_cnt <= 16'd0;
			end else if (ctrl.head_home) begin
				transfer_cnt  <= 16'd0;
				disk_pos      <= 16'd0;
				after_pre_gap <= 1'b0;
			end else if (!after_pre_gap) begin
				if (transfer_cnt == PRE_GAP_CYCLES) begin  // Lead-in done
					after_pre_gap <= 1'b1;
					transfer_cnt  <= 16'd0;
				end else begin
					transfer_cnt <= transfer_cnt + 16'd1;
				end
			end else if (transfer_cnt == BYTE_CYCLES) begin
				transfer_cnt <= 16'd0;
				if (ctrl.transfer_on && !drive_busy) begin
					byte_ready <= 1'b1;
					new_byte   <= 1'b1;
				end
			end else begin
				transfer_cnt <= transfer_cnt + 16'd1;
			end

			// Rising transfer_on opens a new block
			if (ctrl.transfer_on && !xfer_d) begin
				byte_ready  <= ctrl.write_mode;
				new_byte    <= 1'b0;
				got_start   <= 1'b0;
				got_start_d <= 1'b0;
				byte_cnt    <= 16'd0;
				block_end   <= 1'b0;
				block_type  <= 3'd0;
				if (after_pre_gap)
					transfer_cnt <= 16'd0;
			end
		end
	end

	a_pos_in_range: assert property (@(posedge clk) disable iff (diskreset)
		disk_pos <= `FDS_DISK_END_POS);

endmodule

`default_nettype wire

// File: logic/fds_disk_side.sv
// Eject button edge, disk side stepping, minimum eject hold and side image offset
`timescale 1ns/10ps
`default_nettype none

`include "fds_defines.svh"

module fds_disk_side #(
	parameter logic [22:0] EJECT_HOLD_CYCLES = `FDS_EJECT_DEFAULT
) (
	input  logic        clk,
	input  logic        diskreset,
	input  logic        ce,
	input  logic        eject_btn,
	input  logic        write_mode,
	input  logic [1:0]  max_diskside,
	output logic [1:0]  diskside,
	output logic        disk_eject,
	output logic [17:0] side_offset
);

	localparam logic [17:0] SIDE_BYTES   = 18'(`FDS_SIDE_BYTES);
	localparam logic [17:0] IMAGE_HEADER = 18'(`FDS_IMAGE_HEADER);

	logic        btn_d;
	logic        hold;
	logic [22:0] hold_cnt;

	always_ff @(posedge clk) begin
		if (diskreset) begin
			btn_d    <= 1'b0;
			hold     <= 1'b0;
			hold_cnt <= 23'd0;
			diskside <= 2'd0;
		end else if (ce) begin
			btn_d <= eject_btn;
			if (eject_btn && !btn_d && !write_mode) begin
				diskside <= (diskside >= max_diskside) ? 2'd0 : diskside + 2'd1;
				hold     <= 1'b1;
				hold_cnt <= 23'd0;
			end else if (hold) begin
				if (hold_cnt == EJECT_HOLD_CYCLES)
					hold <= 1'b0;  // Minimum eject time served
				else
					hold_cnt <= hold_cnt + 23'd1;
			end
		end
	end

	assign disk_eject  = hold | eject_btn;
	assign side_offset = IMAGE_HEADER + 18'(diskside) * SIDE_BYTES;

	a_side_in_range: assert property (@(posedge clk) disable iff (diskreset)
		diskside <= max_diskside);

endmodule

`default_nettype wire

// File: logic/fds_host_bus.sv
// Register decode, control register, read-back mux, PRG/CHR mapping and IRQ merge
`timescale 1ns/10ps
`default_nettype none

`include "fds_defines.svh"

module fds_host_bus import fds_pkg::*; (
	input  logic         clk,
	input  logic         diskreset,
	input  logic         ce,
	input  cpu_bus_t     cpu,
	input  logic [13:0]  chr_ain,
	input  disk_status_t status,
	input  logic         timer_irq,
	input  logic         disk_irq,
	input  logic         disk_eject,
	input  logic         disk_access,
	input  logic [15:0]  disk_pos,
	input  logic [17:0]  side_offset,
	output disk_ctrl_t   ctrl,
	output logic         data_write,
	output logic         data_read,
	output logic         status_read,
	output logic [7:0]   prg_dout,
	output logic         prg_bus_write,
	output logic         irq,
	output prg_map_t     prg,
	output logic [21:0]  chr_aout,
	output logic         vram_a10,
	output logic         vram_ce
);

	logic        disk_ready;
	logic        prg_is_ram;
	logic [5:0]  prg_bank;
	logic [17:0] image_off;

	always_ff @(posedge clk) begin
		if (diskreset) begin
			ctrl <= '0;
		end else if (ce && cpu.write && cpu.addr == `FDS_ADDR_CTRL) begin
			ctrl.motor_on        <= cpu.wdata[0];
			ctrl.head_home       <= cpu.wdata[1];
			ctrl.write_mode      <= ~cpu.wdata[2];  // Bit 2 low selects write
			ctrl.vertical_mirror <= ~cpu.wdata[3];
			ctrl.transfer_on     <= cpu.wdata[6];
			ctrl.disk_irq_en     <= cpu.wdata[7];
		end
	end

	assign data_write  = cpu.write & (cpu.addr == `FDS_ADDR_WDATA);
	assign data_read   = cpu.read & (cpu.addr == `FDS_ADDR_RDATA);
	assign status_read = cpu.read & (cpu.addr == `FDS_ADDR_STATUS);

	assign disk_ready = ~disk_eject & ~ctrl.head_home & ctrl.motor_on & ~status.disk_end;

	always_comb begin
		prg_bus_write = cpu.read;
		case (cpu.addr)
			`FDS_ADDR_STATUS: prg_dout = {1'b0, status.disk_end, 4'd0, status.byte_ready, timer_irq};
			`FDS_ADDR_DRIVE:  prg_dout = {4'h4, 1'b0, disk_eject, ~disk_ready, disk_eject};
			`FDS_ADDR_EXT:    prg_dout = 8'h80;
			default: begin
				prg_dout      = 8'd0;
				prg_bus_write = 1'b0;
			end
		endcase
	end

	// $6000-$DFFF is work RAM, the rest of the upper half is BIOS
	assign prg_is_ram = cpu.addr[15] ^ (&cpu.addr[14:13]);
	assign prg_bank   = prg_is_ram ? {4'b0001, cpu.addr[14:13]} : 6'd0;
	assign image_off  = side_offset + 18'(disk_pos);

	assign prg.aout = disk_access ? {{(`FDS_PRG_AW-18){1'b1}}, image_off}
		: {{(`FDS_PRG_AW-19){1'b0}}, prg_bank, cpu.addr[12:0]};
	assign prg.allow = (cpu.read & cpu.addr[15] & ~prg_bus_write) | prg_is_ram | disk_access;

	assign irq = timer_irq | disk_irq;

	assign chr_aout = {9'b10_0000_000, chr_ain[12:0]};  // Fixed 8 KB CHR RAM
	assign vram_a10 = ctrl.vertical_mirror ? chr_ain[10] : chr_ain[11];
	assign vram_ce  = chr_ain[13];

endmodule

`default_nettype wire

// File: logic/fds_disk_top.sv
// Disk drive side of the cartridge adapter, host bus, timer, transfer and side select
`timescale 1ns/10ps
`default_nettype none

`include "fds_defines.svh"

module fds_disk_top import fds_pkg::*; #(
	parameter logic [15:0] PRE_GAP_CYCLES    = `FDS_PRE_GAP_DEFAULT,
	parameter logic [15:0] BYTE_CYCLES       = `FDS_BYTE_DEFAULT,
	parameter logic [22:0] EJECT_HOLD_CYCLES = `FDS_EJECT_DEFAULT
) (
	input  logic        clk,
	input  logic        diskreset,
	input  logic        ce,
	input  cpu_bus_t    cpu,
	input  logic [7:0]  prg_dbus,
	input  logic [13:0] chr_ain,
	input  logic        eject_btn,
	input  logic [1:0]  max_diskside,
	input  logic        drive_busy,
	output logic [7:0]  prg_dout,
	output logic        prg_bus_write,
	output prg_map_t    prg,
	output logic [21:0] chr_aout,
	output logic        vram_a10,
	output logic        vram_ce,
	output logic        irq,
	output logic [1:0]  diskside
);

	disk_ctrl_t   ctrl;
	disk_status_t status;
	logic         data_write;
	logic         data_read;
	logic         status_read;
	logic         disk_irq;
	logic         timer_irq;
	logic         disk_access;
	logic         disk_eject;
	logic [15:0]  disk_pos;
	logic [17:0]  side_offset;

	fds_host_bus u_host_bus (
		.clk(clk), .diskreset(diskreset), .ce(ce), .cpu(cpu), .chr_ain(chr_ain),
		.status(status), .timer_irq(timer_irq), .disk_irq(disk_irq),
		.disk_eject(disk_eject), .disk_access(disk_access), .disk_pos(disk_pos),
		.side_offset(side_offset), .ctrl(ctrl), .data_write(data_write),
		.data_read(data_read), .status_read(status_read), .prg_dout(prg_dout),
		.prg_bus_write(prg_bus_write), .irq(irq), .prg(prg), .chr_aout(chr_aout),
		.vram_a10(vram_a10), .vram_ce(vram_ce)
	);

	fds_interval_timer u_timer (
		.clk(clk), .diskreset(diskreset), .ce(ce), .cpu(cpu),
		.status_read(status_read), .timer_irq(timer_irq)
	);

	fds_byte_transfer #(
		.PRE_GAP_CYCLES(PRE_GAP_CYCLES), .BYTE_CYCLES(BYTE_CYCLES)
	) u_transfer (
		.clk(clk), .diskreset(diskreset), .ce(ce), .ctrl(ctrl), .cpu(cpu),
		.data_write(data_write), .data_read(data_read), .status_read(status_read),
		.drive_busy(drive_busy), .prg_dbus(prg_dbus), .status(status),
		.disk_irq(disk_irq), .disk_pos(disk_pos), .disk_access(disk_access)
	);

	fds_disk_side #(
		.EJECT_HOLD_CYCLES(EJECT_HOLD_CYCLES)
	) u_disk_side (
		.clk(clk), .diskreset(diskreset), .ce(ce), .eject_btn(eject_btn),
		.write_mode(ctrl.write_mode), .max_diskside(max_diskside),
		.diskside(diskside), .disk_eject(disk_eject), .side_offset(side_offset)
	);

endmodule

`default_nettype wire

// File: dv/fds_disk_tb.sv
// Disk drive testbench with timer, register read, CHR map, transfer, block end and eject checks
`timescale 1ns/10ps
`default_nettype none

`include "fds_defines.svh"

module fds_disk_tb import fds_pkg::*; ();

	localparam int PRE_GAP     = 40;
	localparam int BYTE_PER    = 9;
	localparam int EJECT_HOLD  = 30;
	localparam int MAX_SIDE    = 1;
	localparam int TIMER_LOAD  = 12;
	localparam int WINDOW_BASE = 32'h003C_0000;  // Top 256 KB of the 4 MB PRG space
	localparam int MAX_CYCLES  = 20000;          // Far above the few hundred cycles the tests take

	logic        clk;
	logic        diskreset;
	logic        ce;
	cpu_bus_t    cpu;
	logic [7:0]  prg_dbus;
	logic [13:0] chr_ain;
	logic        eject_btn;
	logic [1:0]  max_diskside;
	logic        drive_busy;
	logic [7:0]  prg_dout;
	logic        prg_bus_write;
	prg_map_t    prg;
	logic [21:0] chr_aout;
	logic        vram_a10;
	logic        vram_ce;
	logic        irq;
	logic [1:0]  diskside;

	integer seed;
	int     errors = 0;
	int     checks = 0;
	int     ce_count = 0;     // Enabled clock edges since reset
	int     cycle_count = 0;

	fds_disk_top #(
		.PRE_GAP_CYCLES(16'(PRE_GAP)), .BYTE_CYCLES(16'(BYTE_PER)),
		.EJECT_HOLD_CYCLES(23'(EJECT_HOLD))
	) UUT (
		.clk(clk), .diskreset(diskreset), .ce(ce), .cpu(cpu), .prg_dbus(prg_dbus),
		.chr_ain(chr_ain), .eject_btn(eject_btn), .max_diskside(max_diskside),
		.drive_busy(drive_busy), .prg_dout(prg_dout), .prg_bus_write(prg_bus_write),
		.prg(prg), .chr_aout(chr_aout), .vram_a10(vram_a10), .vram_ce(vram_ce),
		.irq(irq), .diskside(diskside)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (ce && !diskreset)
			ce_count <= ce_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Run stopped at %0t, tests did not finish within %0d cycles",
				$time, MAX_CYCLES);
			$display("Checks %0d, errors %0d", checks, errors + 1);
			$display("Errors found");
			$finish;
		end
	end

	task automatic log_mismatch(input string msg);
		errors++;
		$display("mismatch at %0t: %s", $time, msg);
	endtask

	task automatic check_equal(input int got, input int exp, input string what);
		checks++;
		assert (got == exp)
			else log_mismatch($sformatf("%s got %0d expected %0d", what, got, exp));
	endtask

	function automatic logic random_ce();
		logic [31:0] r;
		r = $random(seed);
		return r[0] | r[1];  // About three ce in four
	endfunction

	function automatic int next_side(input int s);
		return (s >= MAX_SIDE) ? 0 : s + 1;
	endfunction

	// Drive on the rising edge, return at the falling edge where outputs are settled
	task automatic bus_cycle(input cpu_bus_t acc, input logic ce_val);
		@(posedge clk);
		cpu <= acc;
		ce  <= ce_val;
		@(negedge clk);
	endtask

	task automatic idle();
		bus_cycle('0, random_ce());
	endtask

	task automatic write_reg(input logic [15:0] addr, input logic [7:0] data);
		bus_cycle('{addr: addr, wdata: data, read: 1'b0, write: 1'b1}, 1'b1);
	endtask

	task automatic read_reg(input logic [15:0] addr, output logic [7:0] data);
		bus_cycle('{addr: addr, wdata: 8'h00, read: 1'b1, write: 1'b0}, 1'b1);
		data = prg_dout;
	endtask

	task automatic read_disk_byte(input logic [7:0] data);
		@(posedge clk);
		cpu      <= '{addr: `FDS_ADDR_RDATA, wdata: 8'h00, read: 1'b1, write: 1'b0};
		prg_dbus <= data;  // Memory answers from the image
		ce       <= 1'b1;
		@(negedge clk);
	endtask

	task automatic press_eject();
		@(posedge clk);
		cpu       <= '0;
		eject_btn <= 1'b1;
		ce        <= 1'b1;
		@(negedge clk);
		@(posedge clk);
		eject_btn <= 1'b0;
		ce        <= 1'b1;  // Release is seen before any further press
		@(negedge clk);
	endtask

	// CHR RAM sits at 2 MB, nametables go to console VRAM
	task automatic compare_chr_map(input logic vertical);
		logic [13:0] a;
		for (int k = 0; k < 16; k++) begin
			a = {4'(k), 10'h155};
			@(posedge clk);
			cpu     <= '0;
			ce      <= random_ce();
			chr_ain <= a;
			@(negedge clk);
			check_equal(int'(chr_aout), 32'h0020_0000 + int'(a[12:0]), "chr_aout");
			check_equal(int'(vram_a10), int'(vertical ? a[10] : a[11]), "vram_a10");
			check_equal(int'(vram_ce), int'(a[13]), "vram_ce");
		end
	endtask

	task automatic wait_irq(input int limit, output bit seen);
		int n;
		n = 0;
		while (!irq && n < limit) begin
			idle();
			n++;
		end
		seen = irq;
		if (!seen) begin
			errors++;
			$display("irq did not rise within %0d cycles, at %0t", limit, $time);
		end
	endtask

	a_bus_write_on_read: assert property (@(negedge clk) disable iff (diskreset)
		prg_bus_write |-> cpu.read && (cpu.addr == `FDS_ADDR_STATUS ||
			cpu.addr == `FDS_ADDR_DRIVE || cpu.addr == `FDS_ADDR_EXT))
		else log_mismatch("prg_bus_write high outside a fixed register read");

	a_side_bound: assert property (@(negedge clk) disable iff (diskreset)
		diskside <= max_diskside)
		else log_mismatch("diskside above max_diskside");

	initial begin
		bit          seen;
		logic [7:0]  d;
		cpu_bus_t    drive_rd;
		int          mark;
		int          flag_mark;
		int          side_model;
		int          pos_model;
		int          taken;
		int          exp_aout;

		seed         = 66;
		cpu          = '0;
		ce           = 1'b0;
		prg_dbus     = 8'h00;
		chr_ain      = 14'h0000;
		eject_btn    = 1'b0;
		max_diskside = 2'(MAX_SIDE);
		drive_busy   = 1'b0;
		diskreset    = 1'b1;
		side_model   = 0;
		flag_mark    = 0;
		drive_rd     = '{addr: `FDS_ADDR_DRIVE, wdata: 8'h00, read: 1'b1, write: 1'b0};
		repeat (8) @(posedge clk);
		diskreset <= 1'b0;

		// One-shot timer
		write_reg(`FDS_ADDR_IOEN, 8'h01);
		write_reg(`FDS_ADDR_TLO, 8'(TIMER_LOAD));
		write_reg(`FDS_ADDR_THI, 8'h00);
		write_reg(`FDS_ADDR_TCTL, 8'h02);
		idle();
		mark = ce_count;  // Edge that took the enable
		wait_irq(200, seen);
		check_equal(ce_count - mark, TIMER_LOAD + 1, "timer irq ce count");
		read_reg(`FDS_ADDR_STATUS, d);
		check_equal(int'(d[0]), 1, "status timer bit");
		bus_cycle('0, 1'b1);
		bus_cycle('0, 1'b1);
		repeat (40) begin
			check_equal(int'(irq), 0, "irq after status read");
			idle();
		end

		read_reg(`FDS_ADDR_EXT, d);
		check_equal(int'(d), 'h80, "$4033 value");
		check_equal(int'(prg_bus_write), 1, "$4033 bus drive");
		read_reg(`FDS_ADDR_DRIVE, d);
		check_equal(int'(d[7:4]), 4, "$4032 upper nibble");
		check_equal(int'(d[1]), 1, "$4032 not ready with motor off");
		check_equal(int'(d[0]), 0, "$4032 eject before any press");

		// Horizontal nametables, read mode, motor off
		write_reg(`FDS_ADDR_CTRL, 8'h0C);
		compare_chr_map(1'b0);

		// Eject hold seen through $4032
		press_eject();
		mark = ce_count;
		side_model = next_side(side_model);
		check_equal(int'(diskside), side_model, "side after first eject");
		while (ce_count - mark <= EJECT_HOLD + 1) begin
			bus_cycle(drive_rd, random_ce());
			check_equal(int'(prg_dout[0]), int'(ce_count - mark <= EJECT_HOLD), "eject bit 0");
			check_equal(int'(prg_dout[2]), int'(ce_count - mark <= EJECT_HOLD), "eject bit 2");
		end
		repeat (2) begin
			press_eject();
			side_model = next_side(side_model);
			check_equal(int'(diskside), side_model, "side after eject");
		end
		write_reg(`FDS_ADDR_CTRL, 8'h00);  // Write mode, motor off
		compare_chr_map(1'b1);
		press_eject();
		check_equal(int'(diskside), side_model, "side after eject in write mode");

		// Motor on, read mode, transfer on, disk IRQ on
		write_reg(`FDS_ADDR_CTRL, 8'hC5);
		idle();
		mark      = ce_count;
		pos_model = 0;
		taken     = 0;
		for (int i = 0; i < 5; i++) begin
			wait_irq(200, seen);
			if (i == 0)
				check_equal(ce_count - mark, PRE_GAP + 1 + BYTE_PER + 1, "first byte slot");
			else
				check_equal(ce_count - flag_mark, BYTE_PER + 1, "byte period");
			flag_mark = ce_count;
			if (i == 0) begin
				read_reg(`FDS_ADDR_STATUS, d);
				check_equal(int'(d[1]), 1, "status byte ready bit");
			end
			exp_aout = WINDOW_BASE + `FDS_IMAGE_HEADER + side_model * `FDS_SIDE_BYTES + pos_model;
			read_disk_byte((i == 0) ? 8'h02 : 8'h5A);  // Type 2 block
			check_equal(int'(prg.aout), exp_aout, "disk window address");
			check_equal(int'(prg.allow), 1, "disk window allow");
			bus_cycle('0, 1'b1);
			bus_cycle('0, 1'b1);
			check_equal(int'(irq), 0, "irq after data read");
			if (taken <= int'(`FDS_BLK_COUNT_LEN))
				pos_model++;
			taken++;
		end

		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: fds_disk_top.f
+incdir+logic
logic/fds_pkg.sv
logic/fds_interval_timer.sv
logic/fds_byte_transfer.sv
logic/fds_disk_side.sv
logic/fds_host_bus.sv
logic/fds_disk_top.sv
dv/fds_disk_tb.sv

// File: Makefile
# Verilator build and run for the disk drive testbench

VERILATOR ?= verilator
TOP       ?= fds_disk_tb
RTL_TOP   ?= fds_disk_top
FILELIST  ?= fds_disk_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Errors found
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(SRCS) $(FILELIST) logic/fds_defines.svh
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
